//--- hw/rvPkg.sv
package rvPkg;

   // Common widths
   typedef logic [31:0] word_t;
   typedef logic [4:0]  regAddr_t;
   typedef logic [3:0]  byteMask_t;
   typedef logic [3:0]  aluOp_t;
   typedef logic [1:0]  wbSel_t;

   // ALU operation codes
   localparam aluOp_t aluAdd  = 4'd0;
   localparam aluOp_t aluSub  = 4'd1;
   localparam aluOp_t aluSll  = 4'd2;
   localparam aluOp_t aluSlt  = 4'd3;
   localparam aluOp_t aluSltu = 4'd4;
   localparam aluOp_t aluXor  = 4'd5;
   localparam aluOp_t aluSrl  = 4'd6;
   localparam aluOp_t aluSra  = 4'd7;
   localparam aluOp_t aluOr   = 4'd8;
   localparam aluOp_t aluAnd  = 4'd9;

   // Writeback sources
   localparam wbSel_t wbAlu  = 2'd0;
   localparam wbSel_t wbLoad = 2'd1;
   localparam wbSel_t wbLink = 2'd2;

   // RV32I major opcodes
   localparam logic [6:0] opOp     = 7'b0110011;
   localparam logic [6:0] opOpImm  = 7'b0010011;
   localparam logic [6:0] opLui    = 7'b0110111;
   localparam logic [6:0] opAuipc  = 7'b0010111;
   localparam logic [6:0] opJal    = 7'b1101111;
   localparam logic [6:0] opJalr   = 7'b1100111;
   localparam logic [6:0] opBranch = 7'b1100011;
   localparam logic [6:0] opLoad   = 7'b0000011;
   localparam logic [6:0] opStore  = 7'b0100011;

   // addi x0, x0, 0
   localparam word_t nopInstr = 32'h0000_0013;

endpackage

//--- hw/syncRam.sv
`timescale 1ns/100ps

module syncRam
#(
   parameter int addrBits = 10
)
(
   input  logic              clk,
   input  rvPkg::byteMask_t  we,
   input  logic [addrBits-1:0] waddr,
   input  rvPkg::word_t      wdata,
   input  logic              re,
   input  logic [addrBits-1:0] raddr,
   output rvPkg::word_t      rdata
);
   import rvPkg::*;

   word_t mem [0:(1<<addrBits)-1];

   // Per-byte write lanes
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < 4; i++)
      begin
         if (we[i])
            mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
      end
   end

   // Output register only loads on re, so it holds otherwise
   always_ff @(posedge clk)
   begin
      if (re)
         rdata <= mem[raddr];
   end

endmodule

//--- hw/regFile.sv
`timescale 1ns/100ps

module regFile
(
   input  logic            clk,
   input  logic            we,
   input  rvPkg::regAddr_t ra1,
   input  rvPkg::regAddr_t ra2,
   input  rvPkg::regAddr_t wa,
   input  rvPkg::word_t    wd,
   output rvPkg::word_t    rd1,
   output rvPkg::word_t    rd2
);
   import rvPkg::*;

   word_t regs [1:31];

   always_ff @(posedge clk)
   begin
      if (we && wa != 5'd0)
         regs[wa] <= wd;
   end

   // x0 always reads as zero
   assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

//--- hw/alu.sv
`timescale 1ns/100ps

module alu
(
   input  rvPkg::word_t  a,
   input  rvPkg::word_t  b,
   input  rvPkg::aluOp_t op,
   output rvPkg::word_t  result,
   output logic          taken,
   input  logic [2:0]    funct3
);
   import rvPkg::*;

   logic       isEq;
   logic       isLt;
   logic       isLtu;
   logic [4:0] shamt;

   assign isEq  = (a == b);
   assign isLt  = ($signed(a) < $signed(b));
   assign isLtu = (a < b);
   assign shamt = b[4:0];

   always_comb
   begin
      case (op)
         aluSub:  result = a - b;
         aluSll:  result = a << shamt;
         aluSlt:  result = {31'd0, isLt};
         aluSltu: result = {31'd0, isLtu};
         aluXor:  result = a ^ b;
         aluSrl:  result = a >> shamt;
         aluSra:  result = word_t'($signed(a) >>> shamt);
         aluOr:   result = a | b;
         aluAnd:  result = a & b;
         default: result = a + b;
      endcase
   end

   // Branch condition from funct3, same compare as slt/sltu
   always_comb
   begin
      case (funct3)
         3'b000:  taken = isEq;
         3'b001:  taken = ~isEq;
         3'b100:  taken = isLt;
         3'b101:  taken = ~isLt;
         3'b110:  taken = isLtu;
         3'b111:  taken = ~isLtu;
         default: taken = 1'b0;
      endcase
   end

endmodule

//--- hw/instDecode.sv
`timescale 1ns/100ps

module instDecode
(
   input  rvPkg::word_t    instr,
   output rvPkg::regAddr_t rs1,
   output rvPkg::regAddr_t rs2,
   output rvPkg::regAddr_t rd,
   output logic [2:0]      funct3,
   output rvPkg::word_t    imm,
   output rvPkg::aluOp_t   aluOp,
   output logic            useImmB,
   output logic            useZeroA,
   output logic            usePcA,
   output logic            isBranch,
   output logic            isJal,
   output logic            isJalr,
   output logic            isLoad,
   output logic            isStore,
   output logic            regWe,
   output rvPkg::wbSel_t   wbSel
);
   import rvPkg::*;

   logic [6:0] opcode;
   logic       alt;
   word_t      immI;
   word_t      immS;
   word_t      immB;
   word_t      immU;
   word_t      immJ;

   // Shared funct3 to ALU op mapping for OP and OP-IMM
   function automatic aluOp_t mapAluOp(input logic [2:0] f3, input logic subSra);
      case (f3)
         3'b000:  mapAluOp = subSra ? aluSub : aluAdd;
         3'b001:  mapAluOp = aluSll;
         3'b010:  mapAluOp = aluSlt;
         3'b011:  mapAluOp = aluSltu;
         3'b100:  mapAluOp = aluXor;
         3'b101:  mapAluOp = subSra ? aluSra : aluSrl;
         3'b110:  mapAluOp = aluOr;
         default: mapAluOp = aluAnd;
      endcase
   endfunction

   assign opcode = instr[6:0];
   assign rd     = instr[11:7];
   assign funct3 = instr[14:12];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];
   assign alt    = instr[30];

   assign immI = {{20{instr[31]}}, instr[31:20]};
   assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immU = {instr[31:12], 12'd0};
   assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb
   begin
      imm      = immI;
      aluOp    = aluAdd;
      useImmB  = 1'b0;
      useZeroA = 1'b0;
      usePcA   = 1'b0;
      isBranch = 1'b0;
      isJal    = 1'b0;
      isJalr   = 1'b0;
      isLoad   = 1'b0;
      isStore  = 1'b0;
      regWe    = 1'b0;
      wbSel    = wbAlu;
      case (opcode)
         opOp:
         begin
            aluOp = mapAluOp(funct3, alt);
            regWe = 1'b1;
         end
         opOpImm:
         begin
            // Only the shift-right form reads funct7 bit 5
            aluOp   = mapAluOp(funct3, alt && funct3 == 3'b101);
            useImmB = 1'b1;
            regWe   = 1'b1;
         end
         opLui:
         begin
            imm      = immU;
            useImmB  = 1'b1;
            useZeroA = 1'b1;
            regWe    = 1'b1;
         end
         opAuipc:
         begin
            imm     = immU;
            useImmB = 1'b1;
            usePcA  = 1'b1;
            regWe   = 1'b1;
         end
         opJal:
         begin
            imm   = immJ;
            isJal = 1'b1;
            regWe = 1'b1;
            wbSel = wbLink;
         end
         opJalr:
         begin
            useImmB = 1'b1;
            isJalr  = 1'b1;
            regWe   = 1'b1;
            wbSel   = wbLink;
         end
         opBranch:
         begin
            imm      = immB;
            isBranch = 1'b1;
         end
         opLoad:
         begin
            useImmB = 1'b1;
            isLoad  = 1'b1;
            regWe   = 1'b1;
            wbSel   = wbLoad;
         end
         opStore:
         begin
            imm     = immS;
            useImmB = 1'b1;
            isStore = 1'b1;
         end
         default:
         begin
            // Unknown opcodes behave as a bubble
            imm = immI;
         end
      endcase
   end

endmodule

//--- hw/loadStoreAlign.sv
`timescale 1ns/100ps

module loadStoreAlign
(
   input  logic             storeEn,
   input  logic [2:0]       funct3,
   input  logic [1:0]       addrLow,
   input  rvPkg::word_t     storeIn,
   output rvPkg::byteMask_t mask,
   output rvPkg::word_t     storeOut,
   input  logic [2:0]       loadFunct3,
   input  logic [1:0]       loadAddrLow,
   input  rvPkg::word_t     ramWord,
   output rvPkg::word_t     loadOut
);
   import rvPkg::*;

   word_t shifted;

   // Store side, data copied to every lane and the mask picks the lane
   always_comb
   begin
      case (funct3[1:0])
         2'b00:
         begin
            storeOut = {4{storeIn[7:0]}};
            mask     = 4'b0001 << addrLow;
         end
         2'b01:
         begin
            storeOut = {2{storeIn[15:0]}};
            mask     = 4'b0011 << {addrLow[1], 1'b0};
         end
         default:
         begin
            storeOut = storeIn;
            mask     = 4'b1111;
         end
      endcase
      if (!storeEn)
         mask = 4'b0000;
   end

   // Load side
   assign shifted = ramWord >> {loadAddrLow, 3'b000};

   always_comb
   begin
      case (loadFunct3)
         3'b000:  loadOut = {{24{shifted[7]}}, shifted[7:0]};
         3'b001:  loadOut = {{16{shifted[15]}}, shifted[15:0]};
         3'b100:  loadOut = {24'd0, shifted[7:0]};
         3'b101:  loadOut = {16'd0, shifted[15:0]};
         default: loadOut = ramWord;
      endcase
   end

endmodule

//--- hw/rvCore.sv
`timescale 1ns/100ps

module rvCore
#(
   parameter int imemAddrBits = 10
)
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    stall,
   output logic [imemAddrBits-1:0] imemAddr,
   output logic                    imemRe,
   input  rvPkg::word_t            imemData,
   output rvPkg::word_t            dmemAddr,
   output rvPkg::byteMask_t        dmemWe,
   output rvPkg::word_t            dmemWdata,
   output logic                    dmemRe,
   input  rvPkg::word_t            dmemRdata
);
   import rvPkg::*;

   // Fetch and execute state
   word_t    pc;
   word_t    exPc;
   logic     exFlush;
   word_t    exInstr;

   // Decode outputs
   regAddr_t rs1;
   regAddr_t rs2;
   regAddr_t rd;
   logic [2:0] funct3;
   word_t    imm;
   aluOp_t   aluOp;
   logic     useImmB;
   logic     useZeroA;
   logic     usePcA;
   logic     isBranch;
   logic     isJal;
   logic     isJalr;
   logic     isLoad;
   logic     isStore;
   logic     regWe;
   wbSel_t   exWbSel;

   // Execute datapath
   word_t    rfData1;
   word_t    rfData2;
   word_t    rs1Val;
   word_t    rs2Val;
   word_t    opA;
   word_t    opB;
   word_t    aluResult;
   logic     taken;
   logic     redirect;
   word_t    target;

   // Writeback registers
   word_t    wbResult;
   regAddr_t wbRd;
   logic     wbWe;
   wbSel_t   wbSel;
   word_t    wbLinkAddr;
   logic [2:0] wbFunct3;
   logic [1:0] wbAddrLow;
   word_t    loadValue;
   word_t    wbValue;

   assign imemAddr = pc[imemAddrBits+1:2];
   assign imemRe   = ~stall;

   // A redirected slot becomes a bubble
   assign exInstr = exFlush ? nopInstr : imemData;

   instDecode decode (
      .instr(exInstr), .rs1(rs1), .rs2(rs2), .rd(rd), .funct3(funct3), .imm(imm),
      .aluOp(aluOp), .useImmB(useImmB), .useZeroA(useZeroA), .usePcA(usePcA),
      .isBranch(isBranch), .isJal(isJal), .isJalr(isJalr), .isLoad(isLoad),
      .isStore(isStore), .regWe(regWe), .wbSel(exWbSel)
   );

   regFile regs (
      .clk(clk), .we(wbWe & ~stall & ~rst), .ra1(rs1), .ra2(rs2), .wa(wbRd), .wd(wbValue),
      .rd1(rfData1), .rd2(rfData2)
   );

   // Writeback value overrides the register file read
   assign rs1Val = (wbWe && wbRd != 5'd0 && wbRd == rs1) ? wbValue : rfData1;
   assign rs2Val = (wbWe && wbRd != 5'd0 && wbRd == rs2) ? wbValue : rfData2;

   assign opA = usePcA ? exPc : (useZeroA ? '0 : rs1Val);
   assign opB = useImmB ? imm : rs2Val;

   alu execAlu (
      .a(opA), .b(opB), .op(aluOp), .result(aluResult), .taken(taken), .funct3(funct3)
   );

   assign redirect = isJal | isJalr | (isBranch & taken);
   assign target   = isJalr ? {aluResult[31:1], 1'b0} : exPc + imm;

   assign dmemAddr = aluResult;
   assign dmemRe   = isLoad & ~stall;

   loadStoreAlign lsAlign (
      .storeEn(isStore & ~stall & ~rst), .funct3(funct3), .addrLow(aluResult[1:0]),
      .storeIn(rs2Val), .mask(dmemWe), .storeOut(dmemWdata),
      .loadFunct3(wbFunct3), .loadAddrLow(wbAddrLow), .ramWord(dmemRdata),
      .loadOut(loadValue)
   );

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc      <= '0;
         exPc    <= '0;
         exFlush <= 1'b1;
      end
      else if (!stall)
      begin
         pc      <= redirect ? target : pc + 32'd4;
         exPc    <= pc;
         exFlush <= redirect;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         wbWe <= 1'b0;
      else if (!stall)
         wbWe <= regWe;
   end

   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         wbResult   <= aluResult;
         wbRd       <= rd;
         wbSel      <= exWbSel;
         wbLinkAddr <= exPc + 32'd4;
         wbFunct3   <= funct3;
         wbAddrLow  <= aluResult[1:0];
      end
   end

   always_comb
   begin
      case (wbSel)
         wbLoad:  wbValue = loadValue;
         wbLink:  wbValue = wbLinkAddr;
         default: wbValue = wbResult;
      endcase
   end

endmodule

//--- hw/rvTop.sv
`timescale 1ns/100ps

module rvTop
#(
   parameter int imemAddrBits = 10,
   parameter int dmemAddrBits = 10
)
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    stall,
   input  logic                    progWe,
   input  logic [imemAddrBits-1:0] progAddr,
   input  rvPkg::word_t            progData,
   output logic                    storeValid,
   output rvPkg::word_t            storeAddr,
   output rvPkg::word_t            storeData,
   output rvPkg::byteMask_t        storeMask
);
   import rvPkg::*;

   logic [imemAddrBits-1:0] imemAddr;
   logic                    imemRe;
   word_t                   imemData;
   word_t                   dmemAddr;
   byteMask_t               dmemWe;
   word_t                   dmemWdata;
   logic                    dmemRe;
   word_t                   dmemRdata;

   rvCore #(.imemAddrBits(imemAddrBits)) core (
      .clk(clk), .rst(rst), .stall(stall),
      .imemAddr(imemAddr), .imemRe(imemRe), .imemData(imemData),
      .dmemAddr(dmemAddr), .dmemWe(dmemWe), .dmemWdata(dmemWdata),
      .dmemRe(dmemRe), .dmemRdata(dmemRdata)
   );

   // Write side of the instruction RAM is the programming port
   syncRam #(.addrBits(imemAddrBits)) imem (
      .clk(clk), .we({4{progWe}}), .waddr(progAddr), .wdata(progData),
      .re(imemRe), .raddr(imemAddr), .rdata(imemData)
   );

   syncRam #(.addrBits(dmemAddrBits)) dmem (
      .clk(clk), .we(dmemWe), .waddr(dmemAddr[dmemAddrBits+1:2]), .wdata(dmemWdata),
      .re(dmemRe), .raddr(dmemAddr[dmemAddrBits+1:2]), .rdata(dmemRdata)
   );

   assign storeValid = |dmemWe;
   assign storeAddr  = dmemAddr;
   assign storeData  = dmemWdata;
   assign storeMask  = dmemWe;

endmodule

//--- bench/rvTbEncode.svh
`ifndef RV_TB_ENCODE_SVH
`define RV_TB_ENCODE_SVH

// Instruction encoders, field order as in the RV32I base formats
function automatic word_t rType(input logic [6:0] f7, input regAddr_t rs2, input regAddr_t rs1,
                                input logic [2:0] f3, input regAddr_t rd);
   rType = {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic word_t iType(input logic [11:0] imm, input regAddr_t rs1, input logic [2:0] f3,
                                input regAddr_t rd, input logic [6:0] op);
   iType = {imm, rs1, f3, rd, op};
endfunction

function automatic word_t sType(input logic [11:0] imm, input regAddr_t rs2, input regAddr_t rs1,
                                input logic [2:0] f3);
   sType = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

// Branch offset in bytes, bit 0 dropped
function automatic word_t bType(input logic [12:0] off, input regAddr_t rs1, input regAddr_t rs2,
                                input logic [2:0] f3);
   bType = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic word_t uType(input logic [19:0] upper, input regAddr_t rd, input logic [6:0] op);
   uType = {upper, rd, op};
endfunction

function automatic word_t jType(input logic [20:0] off, input regAddr_t rd);
   jType = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

task automatic checkWord(input string what, input word_t got, input word_t exp);
   if (got !== exp)
   begin
      wordErrors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
   end
endtask

task automatic checkMask(input string what, input byteMask_t got, input byteMask_t exp);
   if (got !== exp)
   begin
      maskErrors++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
   end
endtask

`endif

//--- bench/rvTopTb.sv
`timescale 1ns/100ps

module rvTopTb;
   import rvPkg::*;

   localparam int imemBits = 10;
   localparam int dmemBits = 10;

   // OP table, the SUB row is skipped for OP-IMM
   localparam logic [2:0] opF3 [0:9] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
   localparam logic opAlt [0:9] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
   localparam logic [2:0] brF3 [0:5] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

   logic                clk;
   logic                rst;
   logic                stall;
   logic                progWe;
   logic [imemBits-1:0] progAddr;
   word_t               progData;
   logic                storeValid;
   word_t               storeAddr;
   word_t               storeData;
   byteMask_t           storeMask;

   int          wordErrors;
   int          maskErrors;
   int          otherErrors;
   int          cycles;
   int          limit;
   logic [15:0] lfsr;

   word_t     prog [$];
   word_t     expAddr [$];
   word_t     expData [$];
   byteMask_t expMask [$];
   word_t     gotAddr [$];
   word_t     gotData [$];
   byteMask_t gotMask [$];

   `include "rvTbEncode.svh"

   rvTop #(.imemAddrBits(imemBits), .dmemAddrBits(dmemBits)) uut (
      .clk(clk), .rst(rst), .stall(stall),
      .progWe(progWe), .progAddr(progAddr), .progData(progData),
      .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData),
      .storeMask(storeMask)
   );

   always #5 clk = ~clk;

   // Watchdog
   always @(posedge clk)
   begin
      cycles++;
      if (cycles > limit)
      begin
         $display("Timeout: the expected stores did not arrive within %0d cycles", limit);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // Store tap capture, sampled on the edge that commits the write
   always @(posedge clk)
   begin
      if (storeValid === 1'b1)
      begin
         gotAddr.push_back(storeAddr);
         gotData.push_back(storeData);
         gotMask.push_back(storeMask);
      end
      if (stall && storeValid !== 1'b0)
      begin
         otherErrors++;
         $display("Store strobe was active at %0t while stall was high", $time);
      end
      if (rst && storeValid !== 1'b0)
      begin
         otherErrors++;
         $display("Store strobe was active at %0t during reset", $time);
      end
   end

   // 16-bit Fibonacci LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      lfsrNext = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic word_t randBits(input int n);
      word_t r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsrNext(lfsr);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // RV32I result for OP and OP-IMM
   function automatic word_t refOp(input logic [2:0] f3, input logic alt, input word_t x,
                                   input word_t y);
      case (f3)
         3'd0:    return alt ? x - y : x + y;
         3'd1:    return x << y[4:0];
         3'd2:    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
         3'd3:    return (x < y) ? 32'd1 : 32'd0;
         3'd4:    return x ^ y;
         3'd5:    return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
         3'd6:    return x | y;
         default: return x & y;
      endcase
   endfunction

   function automatic logic branchTaken(input logic [2:0] f3, input word_t x, input word_t y);
      case (f3)
         3'd0:    return x == y;
         3'd1:    return x != y;
         3'd4:    return $signed(x) < $signed(y);
         3'd5:    return $signed(x) >= $signed(y);
         3'd6:    return x < y;
         default: return x >= y;
      endcase
   endfunction

   function automatic word_t laneBits(input byteMask_t m);
      word_t r;
      for (int i = 0; i < 4; i++)
         r[8*i +: 8] = {8{m[i]}};
      return r;
   endfunction

   task automatic emit(input word_t w);
      prog.push_back(w);
   endtask

   task automatic clearProgram();
      prog.delete();
      expAddr.delete();
      expData.delete();
      expMask.delete();
   endtask

   // LUI plus ADDI, upper part rounded for the sign of the low 12 bits
   task automatic loadImm(input regAddr_t rd, input word_t value);
      word_t upper;
      upper = value + 32'h800;
      emit(uType(upper[31:12], rd, opLui));
      emit(iType(value[11:0], rd, 3'd0, rd, opOpImm));
   endtask

   task automatic expectStore(input word_t addr, input word_t data, input byteMask_t mask);
      expAddr.push_back(addr);
      expData.push_back(data);
      expMask.push_back(mask);
   endtask

   task automatic halt();
      emit(jType(21'd0, 5'd0));
   endtask

   // Every R and I operation on random operands, one SW per result
   task automatic arithBlock(input int base);
      word_t a;
      word_t b;
      word_t r;
      word_t imm;
      logic [11:0] field;
      int slot;
      a = randBits(32);
      b = randBits(32);
      loadImm(5'd1, a);
      loadImm(5'd2, b);
      slot = 0;
      for (int k = 0; k < 10; k++)
      begin
         emit(rType(opAlt[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, opF3[k], 5'd3));
         emit(sType(12'(base + 4 * slot), 5'd3, 5'd0, 3'd2));
         expectStore(base + 4 * slot, refOp(opF3[k], opAlt[k], a, b), 4'hF);
         slot++;
      end
      for (int k = 0; k < 10; k++)
      begin
         if (k != 1)
         begin
            r = randBits(12);
            if (opF3[k] == 3'd1 || opF3[k] == 3'd5)
            begin
               field = {opAlt[k] ? 7'h20 : 7'h00, r[4:0]};
               imm = {27'd0, r[4:0]};
            end
            else
            begin
               field = r[11:0];
               imm = {{20{r[11]}}, r[11:0]};
            end
            emit(iType(field, 5'd1, opF3[k], 5'd3, opOpImm));
            emit(sType(12'(base + 4 * slot), 5'd3, 5'd0, 3'd2));
            expectStore(base + 4 * slot, refOp(opF3[k], opAlt[k], a, imm), 4'hF);
            slot++;
         end
      end
   endtask

   task automatic spacer(input logic padded);
      if (padded)
      begin
         emit(iType(12'd1, 5'd20, 3'd0, 5'd20, opOpImm));
         emit(iType(12'd1, 5'd20, 3'd0, 5'd20, opOpImm));
      end
   endtask

   // Dependent chain with a load feeding the next instruction
   task automatic chainBlock(input int base, input logic padded, input word_t v,
                             input logic [11:0] k1);
      word_t x6;
      word_t x7;
      word_t x10;
      x6 = v + {{20{k1[11]}}, k1};
      x7 = x6 ^ v;
      x10 = (x7 + x6) - x7;
      loadImm(5'd5, v);
      spacer(padded);
      emit(iType(k1, 5'd5, 3'd0, 5'd6, opOpImm));
      spacer(padded);
      emit(rType(7'h00, 5'd5, 5'd6, 3'd4, 5'd7));
      spacer(padded);
      emit(sType(12'(base), 5'd7, 5'd0, 3'd2));
      spacer(padded);
      emit(iType(12'(base), 5'd0, 3'd2, 5'd8, opLoad));
      spacer(padded);
      emit(rType(7'h00, 5'd6, 5'd8, 3'd0, 5'd9));
      spacer(padded);
      emit(rType(7'h20, 5'd7, 5'd9, 3'd0, 5'd10));
      spacer(padded);
      emit(sType(12'(base + 4), 5'd10, 5'd0, 3'd2));
      spacer(padded);
      emit(iType(12'd3, 5'd10, 3'd1, 5'd11, opOpImm));
      spacer(padded);
      emit(sType(12'(base + 8), 5'd11, 5'd0, 3'd2));
      expectStore(base, x7, 4'hF);
      expectStore(base + 4, x10, 4'hF);
      expectStore(base + 8, x10 << 3, 4'hF);
   endtask

   // Writes the program while reset is held, at least 16 cycles
   task automatic loadProgram();
      limit += 4 * prog.size() + 16;
      @(negedge clk);
      rst = 1'b1;
      stall = 1'b0;
      for (int i = 0; i < prog.size() || i < 16; i++)
      begin
         progWe = (i < prog.size());
         progAddr = imemBits'(i);
         progData = (i < prog.size()) ? prog[i] : '0;
         @(negedge clk);
      end
      progWe = 1'b0;
      gotAddr.delete();
      gotData.delete();
      gotMask.delete();
      rst = 1'b0;
   endtask

   task automatic waitStores(input int n);
      while (gotAddr.size() < n)
         @(negedge clk);
   endtask

   task automatic compareStores(input int n);
      word_t lanes;
      if (gotAddr.size() < n)
      begin
         otherErrors++;
         $display("Only %0d of %0d expected stores were seen", gotAddr.size(), n);
      end
      else
      begin
         for (int i = 0; i < n; i++)
         begin
            lanes = laneBits(expMask[i]);
            checkWord("store address", gotAddr[i], expAddr[i]);
            checkWord("store data", gotData[i] & lanes, expData[i] & lanes);
            checkMask("store mask", gotMask[i], expMask[i]);
         end
      end
   endtask

   task automatic arithmeticOps();
      clearProgram();
      arithBlock('h100);
      halt();
      loadProgram();
      waitStores(expAddr.size());
      compareStores(expAddr.size());
   endtask

   task automatic forwardingChain();
      word_t v;
      word_t k;
      v = randBits(32);
      k = randBits(12);
      clearProgram();
      chainBlock('h200, 1'b0, v, k[11:0]);
      chainBlock('h300, 1'b1, v, k[11:0]);
      halt();
      loadProgram();
      waitStores(expAddr.size());
      compareStores(expAddr.size());
   endtask

   task automatic controlFlow();
      word_t a;
      word_t b;
      word_t xa;
      word_t xb;
      word_t pc;
      regAddr_t ra;
      regAddr_t rb;
      int slot;
      // a negative, b positive, so signed and unsigned order differ
      a = randBits(32) | 32'h8000_0000;
      b = randBits(32) & 32'h7fff_ffff;
      clearProgram();
      loadImm(5'd1, a);
      loadImm(5'd2, b);
      slot = 0;
      for (int f = 0; f < 6; f++)
      begin
         for (int p = 0; p < 3; p++)
         begin
            ra = (p == 1) ? 5'd2 : 5'd1;
            rb = (p == 0) ? 5'd2 : 5'd1;
            xa = (p == 1) ? b : a;
            xb = (p == 0) ? b : a;
            emit(bType(13'd12, ra, rb, brF3[f]));
            emit(iType(12'd1, 5'd0, 3'd0, 5'd4, opOpImm));
            emit(jType(21'd8, 5'd0));
            emit(iType(12'd2, 5'd0, 3'd0, 5'd4, opOpImm));
            emit(sType(12'('h400 + 4 * slot), 5'd4, 5'd0, 3'd2));
            expectStore('h400 + 4 * slot, branchTaken(brF3[f], xa, xb) ? 32'd2 : 32'd1, 4'hF);
            slot++;
         end
      end
      // JAL skips two wrong-path stores
      pc = prog.size() * 4;
      emit(jType(21'd12, 5'd5));
      emit(sType(12'h4f0, 5'd5, 5'd0, 3'd2));
      emit(sType(12'h4f0, 5'd5, 5'd0, 3'd2));
      emit(sType(12'h480, 5'd5, 5'd0, 3'd2));
      expectStore('h480, pc + 4, 4'hF);
      // JALR with an odd offset, bit 0 of the target is cleared
      loadImm(5'd7, (prog.size() + 4) * 4);
      pc = prog.size() * 4;
      emit(iType(12'd1, 5'd7, 3'd0, 5'd8, opJalr));
      emit(sType(12'h4f4, 5'd8, 5'd0, 3'd2));
      emit(sType(12'h484, 5'd8, 5'd0, 3'd2));
      expectStore('h484, pc + 4, 4'hF);
      pc = prog.size() * 4;
      emit(uType(20'h00001, 5'd9, opAuipc));
      emit(sType(12'h488, 5'd9, 5'd0, 3'd2));
      expectStore('h488, pc + 32'h1000, 4'hF);
      halt();
      loadProgram();
      waitStores(expAddr.size());
      compareStores(expAddr.size());
   endtask

   task automatic byteHalfAccess();
      word_t r;
      logic [7:0] b8;
      logic [15:0] h16;
      r = randBits(32);
      // Bytes 0 and 1 negative, bytes 2 and 3 positive
      r[7] = 1'b1;
      r[15] = 1'b1;
      r[23] = 1'b0;
      r[31] = 1'b0;
      clearProgram();
      loadImm(5'd1, r);
      emit(sType(12'h500, 5'd0, 5'd0, 3'd2));
      emit(sType(12'h504, 5'd0, 5'd0, 3'd2));
      expectStore('h500, 32'd0, 4'hF);
      expectStore('h504, 32'd0, 4'hF);
      for (int off = 0; off < 4; off++)
      begin
         emit(iType(12'(8 * off), 5'd1, 3'd5, 5'd2, opOpImm));
         emit(sType(12'('h500 + off), 5'd2, 5'd0, 3'd0));
         expectStore('h500 + off, r, 4'b0001 << off);
      end
      emit(sType(12'h504, 5'd1, 5'd0, 3'd1));
      expectStore('h504, r, 4'b0011);
      emit(iType(12'd16, 5'd1, 3'd5, 5'd2, opOpImm));
      emit(sType(12'h506, 5'd2, 5'd0, 3'd1));
      expectStore('h506, r, 4'b1100);
      for (int off = 0; off < 4; off++)
      begin
         b8 = r[8*off +: 8];
         emit(iType(12'('h500 + off), 5'd0, 3'd0, 5'd3, opLoad));
         emit(sType(12'('h580 + 8 * off), 5'd3, 5'd0, 3'd2));
         expectStore('h580 + 8 * off, {{24{b8[7]}}, b8}, 4'hF);
         emit(iType(12'('h500 + off), 5'd0, 3'd4, 5'd3, opLoad));
         emit(sType(12'('h584 + 8 * off), 5'd3, 5'd0, 3'd2));
         expectStore('h584 + 8 * off, {24'd0, b8}, 4'hF);
      end
      for (int h = 0; h < 2; h++)
      begin
         h16 = r[16*h +: 16];
         emit(iType(12'('h504 + 2 * h), 5'd0, 3'd1, 5'd3, opLoad));
         emit(sType(12'('h5a0 + 8 * h), 5'd3, 5'd0, 3'd2));
         expectStore('h5a0 + 8 * h, {{16{h16[15]}}, h16}, 4'hF);
         emit(iType(12'('h504 + 2 * h), 5'd0, 3'd5, 5'd3, opLoad));
         emit(sType(12'('h5a4 + 8 * h), 5'd3, 5'd0, 3'd2));
         expectStore('h5a4 + 8 * h, {16'd0, h16}, 4'hF);
      end
      emit(iType(12'h500, 5'd0, 3'd2, 5'd3, opLoad));
      emit(sType(12'h5b0, 5'd3, 5'd0, 3'd2));
      expectStore('h5b0, r, 4'hF);
      halt();
      loadProgram();
      waitStores(expAddr.size());
      compareStores(expAddr.size());
   endtask

   task automatic stallSpans();
      int gap [0:5];
      int span [0:5];
      word_t v;
      word_t k;
      v = randBits(32);
      k = randBits(12);
      clearProgram();
      chainBlock('h600, 1'b0, v, k[11:0]);
      arithBlock('h700);
      halt();
      for (int i = 0; i < 6; i++)
      begin
         gap[i] = randBits(2) + 1;
         span[i] = randBits(3) + 1;
         limit += span[i];
      end
      loadProgram();
      for (int i = 0; i < 6; i++)
      begin
         repeat (gap[i]) @(negedge clk);
         stall = 1'b1;
         repeat (span[i]) @(negedge clk);
         stall = 1'b0;
      end
      waitStores(expAddr.size());
      compareStores(expAddr.size());
   endtask

   // Reset lands on the last store of the first chain, then the whole program reruns
   task automatic midReset();
      word_t v;
      word_t k;
      v = randBits(32);
      k = randBits(12);
      clearProgram();
      chainBlock('h780, 1'b0, v, k[11:0]);
      chainBlock('h790, 1'b1, v, k[11:0]);
      halt();
      loadProgram();
      waitStores(2);
      compareStores(2);
      while (storeValid !== 1'b1)
         @(negedge clk);
      limit += 4 * prog.size() + 16;
      rst = 1'b1;
      @(negedge clk);
      gotAddr.delete();
      gotData.delete();
      gotMask.delete();
      repeat (15) @(negedge clk);
      rst = 1'b0;
      waitStores(expAddr.size());
      compareStores(expAddr.size());
   endtask

   initial
   begin
      clk = 1'b0;
      rst = 1'b1;
      stall = 1'b0;
      progWe = 1'b0;
      progAddr = '0;
      progData = '0;
      lfsr = 16'd14;
      cycles = 0;
      limit = 0;
      wordErrors = 0;
      maskErrors = 0;
      otherErrors = 0;
      arithmeticOps();
      forwardingChain();
      controlFlow();
      byteHalfAccess();
      stallSpans();
      midReset();
      $display("Errors: word %0d, mask %0d, other %0d", wordErrors, maskErrors, otherErrors);
      if (wordErrors + maskErrors + otherErrors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

//--- filelist.f
+incdir+bench
hw/rvPkg.sv
hw/syncRam.sv
hw/regFile.sv
hw/alu.sv
hw/instDecode.sv
hw/loadStoreAlign.sv
hw/rvCore.sv
hw/rvTop.sv
bench/rvTopTb.sv

//--- Makefile
# Verilator build and run for the RV32I pipeline testbench

VERILATOR ?= verilator
TOP       ?= rvTopTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST)) bench/rvTbEncode.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
